// File: vlog.f
+incdir+.
arm_isa_pkg.sv
dp_pipe_pkg.sv
hs4_sink.sv
hs4_source.sv
pipe_stage_reg.sv
reg_file.sv
dp_decode_stage.sv
alu_execute_stage.sv
dp_core_top.sv
tb_dp_core.sv

// File: Makefile
# Verilator build and run of the data-processing pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_dp_core
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dp_core_trace.txt
# Columns: instruction word, rd, wrote, cond_met, value, flags as NZCV
# All fields hex; registers and flags start at zero
# Immediate and register operands
E3A000FF 0 1 1 000000FF 0
E3A0143F 1 1 1 3F000000 0
E3A02F02 2 1 1 00000008 0
E0803001 3 1 1 3F0000FF 0
E1824001 4 1 1 3F000008 0
E2845010 5 1 1 3F000018 0
# Arithmetic flags
E0506002 6 1 1 000000F7 2
E0527000 7 1 1 FFFFFF09 8
E1505000 5 0 1 00000000 6
E3E08102 8 1 1 7FFFFFFF 6
E0589007 9 1 1 800000F6 9
E098A008 A 1 1 FFFFFFFE 9
E1570002 0 0 1 FFFFFF01 A
E3A0C102 C 1 1 80000000 A
E25CB001 B 1 1 7FFFFFFF 3
# Logical flags
E010D001 D 1 1 00000000 5
E030E00A E 1 1 FFFFFF01 9
E35C0001 0 0 1 7FFFFFFF 3
E3100080 0 0 1 00000080 1
E1300000 0 0 1 00000000 5
E1D33000 3 1 1 3F000000 1
E1F02002 2 1 1 FFFFFFF7 9
# Condition codes with N set and Z, C, V clear
E1560000 0 0 1 FFFFFFF8 8
03A00040 0 0 0 00000000 8
13A01041 1 1 1 00000041 8
23A02042 2 0 0 00000000 8
33A03043 3 1 1 00000043 8
43A04044 4 1 1 00000044 8
53A05045 5 0 0 00000000 8
63A06046 6 0 0 00000000 8
73A07047 7 1 1 00000047 8
83A08048 8 0 0 00000000 8
93A09049 9 1 1 00000049 8
A3A0A04A A 0 0 00000000 8
B3A0B04B B 1 1 0000004B 8
C3A0C04C C 0 0 00000000 8
D3A0D04D D 1 1 0000004D 8
E3A0E04E E 1 1 0000004E 8
F3A0F04F F 0 0 00000000 8
E1A0F000 F 1 1 000000FF 8
E1A0F006 F 1 1 000000F7 8
E1A0F00C F 1 1 80000000 8
# Dependent chain through the bypass
E2811001 1 1 1 00000042 8
E0811001 1 1 1 00000084 8
E22120FF 2 1 1 0000007B 8
E0423001 3 1 1 FFFFFFF7 8
E1834002 4 1 1 FFFFFFFF 8
E2945001 5 1 1 00000000 6
# Unsupported class and opcodes
E7A06055 6 0 0 00000000 6
E2707001 7 1 1 00000000 6
E0B08000 8 1 1 00000000 6
E1700000 0 1 1 00000000 6
E1A09007 9 1 1 00000000 6
E1A0A006 A 1 1 000000F7 6

// File: tb_dp_core.sv
`timescale 1ns/1ps

`include "dp_core_macros.svh"

module tb_dp_core;

  localparam int CLK_HALF        = 2;    // 4 ns period
  localparam int RESET_CYCLES    = 8;
  localparam int CYCLES_PER_ITEM = 40;   // Watchdog budget per trace line

  logic                    clk_i;
  logic                    reset_i;
  logic                    in_req;
  logic                    in_ack;
  arm_isa_pkg::dp_instr_t  in_word;
  logic                    out_req;
  logic                    out_ack;
  dp_pipe_pkg::dp_result_t out_data;

  logic [`DP_XLEN-1:0]     trace_word [$];
  dp_pipe_pkg::dp_result_t trace_exp  [$];
  int                      n_items;
  int                      n_done;
  int                      error_count;
  logic                    trace_loaded;
  logic [31:0]             lfsr_q;

  dp_core_top uut (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .in_req   (in_req),
    .in_ack   (in_ack),
    .in_word  (in_word),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  // ******************************
  // Random idle gaps
  // ******************************
  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) nxt = nxt ^ 32'h8020_0003;
    return nxt;
  endfunction

  task automatic draw_bits(input int nbits, output int val);
    val = 0;
    for (int i = 0; i < nbits; i++) begin
      val    = (val << 1) | int'(lfsr_q[0]);   // One step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic idle_cycles();
    int n;
    draw_bits(3, n);                           // 0 to 7 cycles
    repeat (n) @(negedge clk_i);
  endtask

  task automatic check_field(input string name, input logic [`DP_XLEN-1:0] exp,
                             input logic [`DP_XLEN-1:0] act);
    if (act !== exp) begin
      error_count++;
      $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
      $display("tests failed");
      $fatal(1, "Result record mismatch");
    end
  endtask

  // ******************************
  // Trace loading
  // ******************************
  task automatic load_trace();
    int                      fd;
    int                      cnt;
    string                   line;
    logic [31:0]             w, rd, wr, cm, val, fl;
    dp_pipe_pkg::dp_result_t rec;
    fd = $fopen("dp_core_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file dp_core_trace.txt");
      $display("tests failed");
      $fatal(1, "Missing trace");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line[0] == "#") continue;   // Comment or blank
        cnt = $sscanf(line, "%h %h %h %h %h %h", w, rd, wr, cm, val, fl);
        if (cnt != 6) begin
          $display("Malformed trace line: %s", line);
          $display("tests failed");
          $fatal(1, "Bad trace");
        end else begin
          rec.rd       = rd[`DP_RIDX_W-1:0];
          rec.wrote    = wr[0];
          rec.cond_met = cm[0];
          rec.value    = val;
          rec.flags    = fl[3:0];
          trace_word.push_back(w);
          trace_exp.push_back(rec);
        end
      end
      $fclose(fd);
      n_items = trace_word.size();
      if (n_items == 0) begin
        $display("The trace file holds no instructions");
        $display("tests failed");
        $fatal(1, "Empty trace");
      end
    end
  endtask

  // ******************************
  // Port drivers
  // ******************************
  task automatic send_words();
    for (int i = 0; i < n_items; i++) begin
      idle_cycles();
      in_word = trace_word[i];
      in_req  = 1'b1;
      do @(negedge clk_i); while (in_ack !== 1'b1);
      in_req = 1'b0;                           // Return to zero
      do @(negedge clk_i); while (in_ack !== 1'b0);
    end
  endtask

  task automatic collect_results();
    dp_pipe_pkg::dp_result_t exp;
    for (int i = 0; i < n_items; i++) begin
      do @(negedge clk_i); while (out_req !== 1'b1);
      idle_cycles();                           // Back-pressure on the output
      exp = trace_exp[i];
      check_field("out_data.rd", {28'b0, exp.rd}, {28'b0, out_data.rd});
      check_field("out_data.wrote", {31'b0, exp.wrote}, {31'b0, out_data.wrote});
      check_field("out_data.cond_met", {31'b0, exp.cond_met}, {31'b0, out_data.cond_met});
      check_field("out_data.value", exp.value, out_data.value);
      check_field("out_data.flags", {28'b0, exp.flags}, {28'b0, out_data.flags});
      out_ack = 1'b1;
      do @(negedge clk_i); while (out_req !== 1'b0);
      out_ack = 1'b0;
      n_done++;
    end
  endtask

  initial begin : watchdog
    wait (trace_loaded === 1'b1);
    repeat (n_items * CYCLES_PER_ITEM + RESET_CYCLES) @(posedge clk_i);
    $display("Timeout: no result arrived in time, %0d of %0d records seen", n_done, n_items);
    $display("tests failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    in_req       = 1'b0;
    in_word      = '0;
    out_ack      = 1'b0;
    reset_i      = 1'b1;
    error_count  = 0;
    n_done       = 0;
    n_items      = 0;
    trace_loaded = 1'b0;
    lfsr_q       = 32'ha8b6a74a;
    load_trace();
    trace_loaded = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk_i);
    reset_i = 1'b0;
    fork
      send_words();
      collect_results();
    join
    if (error_count == 0 && n_done == n_items) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: dp_core_top.sv
`timescale 1ns/1ps

`include "dp_core_macros.svh"

module dp_core_top (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    in_req,
  output logic                    in_ack,
  input  arm_isa_pkg::dp_instr_t  in_word,
  output logic                    out_req,
  input  logic                    out_ack,
  output dp_pipe_pkg::dp_result_t out_data
);

  arm_isa_pkg::dp_instr_t  dec_word;
  dp_pipe_pkg::dp_op_t     dec_op, ex_op;
  dp_pipe_pkg::dp_result_t ex_res, src_res;
  logic                    dec_valid, dec_stall, dec_op_valid, dec_op_stall;
  logic                    ex_valid, ex_stall, ex_res_valid, ex_res_stall;
  logic                    src_valid, src_stall;
  logic [`DP_RIDX_W-1:0]   rd_idx_a, rd_idx_b, wr_idx;
  logic [`DP_XLEN-1:0]     rd_data_a, rd_data_b, wr_data;
  logic                    wr_en;

  hs4_sink u_sink (.clk_i, .reset_i, .in_req, .in_ack, .in_word,
    .valid(dec_valid), .stall(dec_stall), .word(dec_word));

  dp_decode_stage u_decode (.word(dec_word), .valid(dec_valid), .stall_out(dec_stall),
    .op(dec_op), .op_valid(dec_op_valid), .stall_in(dec_op_stall), .rd_idx_a, .rd_idx_b,
    .rd_data_a, .rd_data_b, .byp_en(wr_en), .byp_idx(wr_idx), .byp_data(wr_data));

  pipe_stage_reg #(.payload_t(dp_pipe_pkg::dp_op_t)) u_op_reg (.clk_i, .reset_i,
    .in_valid(dec_op_valid), .in_stall(dec_op_stall), .in_data(dec_op),
    .out_valid(ex_valid), .out_stall(ex_stall), .out_data(ex_op));

  alu_execute_stage u_execute (.clk_i, .reset_i, .op(ex_op), .op_valid(ex_valid),
    .op_stall(ex_stall), .result(ex_res), .result_valid(ex_res_valid),
    .result_stall(ex_res_stall), .wr_en, .wr_idx, .wr_data);

  reg_file u_regs (.clk_i, .reset_i, .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
    .wr_en, .wr_idx, .wr_data);

  pipe_stage_reg #(.payload_t(dp_pipe_pkg::dp_result_t)) u_res_reg (.clk_i, .reset_i,
    .in_valid(ex_res_valid), .in_stall(ex_res_stall), .in_data(ex_res),
    .out_valid(src_valid), .out_stall(src_stall), .out_data(src_res));

  hs4_source u_source (.clk_i, .reset_i, .valid(src_valid), .stall(src_stall),
    .data(src_res), .out_req, .out_ack, .out_data);

endmodule

// File: alu_execute_stage.sv
`timescale 1ns/1ps

`include "dp_core_macros.svh"

module alu_execute_stage (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  dp_pipe_pkg::dp_op_t     op,
  input  logic                    op_valid,
  output logic                    op_stall,
  output dp_pipe_pkg::dp_result_t result,
  output logic                    result_valid,
  input  logic                    result_stall,
  output logic                    wr_en,
  output logic [`DP_RIDX_W-1:0]   wr_idx,
  output logic [`DP_XLEN-1:0]     wr_data
);

  arm_isa_pkg::flags_t flags_q;
  arm_isa_pkg::flags_t flags_next;
  logic [`DP_XLEN:0]   sum;
  logic [`DP_XLEN-1:0] alu_res;
  logic                is_arith;
  logic                is_sub;
  logic                is_logic;
  logic                writes;
  logic                cond_met;
  logic                exec;
  logic                advance;
  logic                ovf;

  assign advance = op_valid && !result_stall;

  // ******************************
  // ALU
  // ******************************
  always_comb begin
    sum      = '0;
    alu_res  = '0;
    is_arith = 1'b0;
    is_sub   = 1'b0;
    is_logic = 1'b1;
    writes   = 1'b1;
    case (op.opcode)
      arm_isa_pkg::OP_AND: alu_res = op.a & op.b;
      arm_isa_pkg::OP_EOR: alu_res = op.a ^ op.b;
      arm_isa_pkg::OP_TST: begin
        alu_res = op.a & op.b;
        writes  = 1'b0;
      end
      arm_isa_pkg::OP_TEQ: begin
        alu_res = op.a ^ op.b;
        writes  = 1'b0;
      end
      arm_isa_pkg::OP_ORR: alu_res = op.a | op.b;
      arm_isa_pkg::OP_MOV: alu_res = op.b;
      arm_isa_pkg::OP_BIC: alu_res = op.a & ~op.b;
      arm_isa_pkg::OP_MVN: alu_res = ~op.b;
      arm_isa_pkg::OP_ADD: begin
        sum      = {1'b0, op.a} + {1'b0, op.b};
        is_arith = 1'b1;
        is_logic = 1'b0;
      end
      arm_isa_pkg::OP_SUB, arm_isa_pkg::OP_CMP: begin
        sum      = {1'b0, op.a} + {1'b0, ~op.b} + 1'b1;  // Carry out means no borrow
        is_arith = 1'b1;
        is_sub   = 1'b1;
        is_logic = 1'b0;
        writes   = (op.opcode == arm_isa_pkg::OP_SUB);
      end
      default: is_logic = 1'b0;                          // Unsupported, zero result
    endcase
    if (is_arith) alu_res = sum[`DP_XLEN-1:0];
  end

  // Same sign in, different sign out; subtract compares against ~b
  assign ovf = is_sub
    ? (op.a[`DP_XLEN-1] != op.b[`DP_XLEN-1]) && (alu_res[`DP_XLEN-1] != op.a[`DP_XLEN-1])
    : (op.a[`DP_XLEN-1] == op.b[`DP_XLEN-1]) && (alu_res[`DP_XLEN-1] != op.a[`DP_XLEN-1]);

  // ******************************
  // Condition check
  // ******************************
  always_comb begin
    case (op.cond)
      arm_isa_pkg::COND_EQ: cond_met = flags_q.z;
      arm_isa_pkg::COND_NE: cond_met = !flags_q.z;
      arm_isa_pkg::COND_CS: cond_met = flags_q.c;
      arm_isa_pkg::COND_CC: cond_met = !flags_q.c;
      arm_isa_pkg::COND_MI: cond_met = flags_q.n;
      arm_isa_pkg::COND_PL: cond_met = !flags_q.n;
      arm_isa_pkg::COND_VS: cond_met = flags_q.v;
      arm_isa_pkg::COND_VC: cond_met = !flags_q.v;
      arm_isa_pkg::COND_HI: cond_met = flags_q.c && !flags_q.z;
      arm_isa_pkg::COND_LS: cond_met = !flags_q.c || flags_q.z;
      arm_isa_pkg::COND_GE: cond_met = (flags_q.n == flags_q.v);
      arm_isa_pkg::COND_LT: cond_met = (flags_q.n != flags_q.v);
      arm_isa_pkg::COND_GT: cond_met = !flags_q.z && (flags_q.n == flags_q.v);
      arm_isa_pkg::COND_LE: cond_met = flags_q.z || (flags_q.n != flags_q.v);
      arm_isa_pkg::COND_AL: cond_met = 1'b1;
      default:              cond_met = 1'b0;              // 1111 never runs
    endcase
  end

  assign exec = cond_met && op.valid_class;

  // ******************************
  // Flag update
  // ******************************
  always_comb begin
    flags_next = flags_q;
    if (exec && op.s) begin
      if (is_arith) begin
        flags_next = '{n: alu_res[`DP_XLEN-1], z: (alu_res == '0), c: sum[`DP_XLEN], v: ovf};
      end else if (is_logic) begin
        flags_next = '{n: alu_res[`DP_XLEN-1], z: (alu_res == '0), c: 1'b0, v: flags_q.v};
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) flags_q <= '0;
    else if (advance) flags_q <= flags_next;
  end

  // Value is reported only for executed instructions
  always_comb begin
    result.rd       = op.rd;
    result.wrote    = exec && writes;
    result.cond_met = exec;
    result.value    = exec ? alu_res : '0;
    result.flags    = flags_next;
  end

  assign result_valid = op_valid;
  assign op_stall     = result_stall;

  assign wr_en   = advance && exec && writes;
  assign wr_idx  = op.rd;
  assign wr_data = alu_res;

  // A register write must coincide with the record leaving downstream
  a_wr_on_move: assert property (@(posedge clk_i) disable iff (reset_i)
    wr_en |-> (result_valid && !result_stall));

endmodule

// File: dp_decode_stage.sv
`timescale 1ns/1ps

`include "dp_core_macros.svh"

module dp_decode_stage (
  input  arm_isa_pkg::dp_instr_t word,
  input  logic                   valid,
  output logic                   stall_out,
  output dp_pipe_pkg::dp_op_t    op,
  output logic                   op_valid,
  input  logic                   stall_in,
  output logic [`DP_RIDX_W-1:0]  rd_idx_a,
  output logic [`DP_RIDX_W-1:0]  rd_idx_b,
  input  logic [`DP_XLEN-1:0]    rd_data_a,
  input  logic [`DP_XLEN-1:0]    rd_data_b,
  input  logic                   byp_en,
  input  logic [`DP_RIDX_W-1:0]  byp_idx,
  input  logic [`DP_XLEN-1:0]    byp_data
);

  logic [`DP_XLEN-1:0]   rn_val;
  logic [`DP_XLEN-1:0]   rm_val;
  logic [`DP_XLEN-1:0]   imm_ext;
  logic [2*`DP_XLEN-1:0] imm_dbl;
  logic [`DP_XLEN-1:0]   imm_rot;
  logic [5:0]            rot_amt;

  // ******************************
  // Operand 2
  // ******************************
  assign imm_ext = {{(`DP_XLEN-8){1'b0}}, word.op2[7:0]};
  assign imm_dbl = {imm_ext, imm_ext};                 // Rotate via double width shift
  assign rot_amt = word.op2[11:8] * `DP_ROT_SCALE;     // 0 to 30
  assign imm_rot = imm_dbl[rot_amt +: `DP_XLEN];

  // ******************************
  // Register reads with bypass
  // ******************************
  assign rd_idx_a = word.rn;
  assign rd_idx_b = word.op2[`DP_RIDX_W-1:0];           // Rm, unshifted

  // Execute writes on the same edge this item advances
  assign rn_val = (byp_en && byp_idx == rd_idx_a) ? byp_data : rd_data_a;
  assign rm_val = (byp_en && byp_idx == rd_idx_b) ? byp_data : rd_data_b;

  always_comb begin
    op.cond        = word.cond;
    op.valid_class = (word.cls == 2'b00);
    op.opcode      = word.opcode;
    op.s           = word.s;
    op.rd          = word.rd;
    op.a           = rn_val;
    op.b           = word.imm ? imm_rot : rm_val;
  end

  assign op_valid  = valid;
  assign stall_out = stall_in;

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

`include "dp_core_macros.svh"

module reg_file (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [`DP_RIDX_W-1:0] rd_idx_a,
  input  logic [`DP_RIDX_W-1:0] rd_idx_b,
  output logic [`DP_XLEN-1:0]   rd_data_a,
  output logic [`DP_XLEN-1:0]   rd_data_b,
  input  logic                  wr_en,
  input  logic [`DP_RIDX_W-1:0] wr_idx,
  input  logic [`DP_XLEN-1:0]   wr_data
);

  logic [`DP_XLEN-1:0] regs_q [`DP_NREGS];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `DP_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wr_idx] <= wr_data;
    end
  end

  // Reads see the old value; decode bypasses a same-cycle write
  assign rd_data_a = regs_q[rd_idx_a];
  assign rd_data_b = regs_q[rd_idx_b];

endmodule

// File: pipe_stage_reg.sv
`timescale 1ns/1ps

module pipe_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     in_valid,
  output logic     in_stall,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_stall,
  output payload_t out_data
);

  logic     valid_q;
  payload_t data_q;
  logic     load;

  // Full and blocked downstream means the upstream must wait
  assign in_stall = valid_q && out_stall;
  assign load     = !in_stall;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load && in_valid) data_q <= in_data;
  end

  assign out_valid = valid_q;
  assign out_data  = data_q;

  // Held item must not change under back-pressure
  a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (out_valid && out_stall) |=> $stable(out_data));

endmodule

// File: hs4_source.sv
`timescale 1ns/1ps

module hs4_source (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    valid,
  output logic                    stall,
  input  dp_pipe_pkg::dp_result_t data,
  output logic                    out_req,
  input  logic                    out_ack,
  output dp_pipe_pkg::dp_result_t out_data
);

  typedef enum logic [1:0] {
    S_IDLE,    // Waiting for an item
    S_LOADED,  // Item held, request not yet raised
    S_REQ,     // Request high, waiting for ack
    S_DROP     // Request low, waiting for ack to fall
  } state_e;

  state_e                  state_q;
  logic                    req_q;
  dp_pipe_pkg::dp_result_t data_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_IDLE;
      req_q   <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE:   if (valid) state_q <= S_LOADED;
        S_LOADED: if (!out_ack) begin
          req_q   <= 1'b1;
          state_q <= S_REQ;
        end
        S_REQ:    if (out_ack) begin
          req_q   <= 1'b0;
          state_q <= S_DROP;
        end
        default:  if (!out_ack) state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE && valid) data_q <= data;
  end

  assign stall    = (state_q != S_IDLE);  // Busy from load until ack falls
  assign out_req  = req_q;
  assign out_data = data_q;

  // No new request while the last ack is still high
  a_req_rise: assert property (@(posedge clk_i) disable iff (reset_i)
    (out_ack && !out_req) |=> !out_req);

endmodule

// File: hs4_sink.sv
`timescale 1ns/1ps

module hs4_sink (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   in_req,
  output logic                   in_ack,
  input  arm_isa_pkg::dp_instr_t in_word,
  output logic                   valid,
  input  logic                   stall,
  output arm_isa_pkg::dp_instr_t word
);

  logic                   ack_q;
  logic                   valid_q;
  arm_isa_pkg::dp_instr_t word_q;
  logic                   take;

  // New request seen and the output slot is empty or leaving
  assign take = in_req && !ack_q && (!valid_q || !stall);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      if (take) ack_q <= 1'b1;
      else if (!in_req) ack_q <= 1'b0;   // Return to zero phase

      if (take) valid_q <= 1'b1;
      else if (!stall) valid_q <= 1'b0;  // Item moved downstream
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) word_q <= in_word;
  end

  assign in_ack = ack_q;
  assign valid  = valid_q;
  assign word   = word_q;

  // Sender must hold the word until it has been acknowledged
  a_word_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (in_req && !in_ack) |=> (!in_req || $stable(in_word)));

endmodule

// File: dp_pipe_pkg.sv
`include "dp_core_macros.svh"

package dp_pipe_pkg;

  // ******************************
  // Decode to execute
  // ******************************
  typedef struct packed {
    arm_isa_pkg::cond_e      cond;
    logic                    valid_class;  // Class bits were 00
    arm_isa_pkg::dp_opcode_e opcode;
    logic                    s;
    logic [`DP_RIDX_W-1:0]   rd;
    logic [`DP_XLEN-1:0]     a;            // Rn value
    logic [`DP_XLEN-1:0]     b;            // Operand 2 value
  } dp_op_t;

  // ******************************
  // Execute to output port
  // ******************************
  typedef struct packed {
    logic [`DP_RIDX_W-1:0] rd;
    logic                  wrote;     // rd was written
    logic                  cond_met;  // Instruction executed
    logic [`DP_XLEN-1:0]   value;
    arm_isa_pkg::flags_t   flags;     // Flags after this instruction
  } dp_result_t;

endpackage

// File: arm_isa_pkg.sv
`include "dp_core_macros.svh"

package arm_isa_pkg;

  // Data-processing opcodes, bits 24:21 of the instruction
  typedef enum logic [3:0] {
    OP_AND = 4'b0000,
    OP_EOR = 4'b0001,
    OP_SUB = 4'b0010,
    OP_ADD = 4'b0100,
    OP_TST = 4'b1000,
    OP_TEQ = 4'b1001,
    OP_CMP = 4'b1010,
    OP_ORR = 4'b1100,
    OP_MOV = 4'b1101,
    OP_BIC = 4'b1110,
    OP_MVN = 4'b1111
  } dp_opcode_e;

  // Condition field, bits 31:28; code 1111 never executes
  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT,
    COND_GT, COND_LE, COND_AL
  } cond_e;

  typedef struct packed {
    logic n;   // Negative
    logic z;   // Zero
    logic c;   // Carry, no borrow on subtract
    logic v;   // Signed overflow
  } flags_t;

  typedef struct packed {
    cond_e                 cond;
    logic [1:0]            cls;     // 00 for data processing
    logic                  imm;     // Operand 2 is an immediate
    dp_opcode_e            opcode;
    logic                  s;       // Update flags
    logic [`DP_RIDX_W-1:0] rn;
    logic [`DP_RIDX_W-1:0] rd;
    logic [11:0]           op2;     // Rotate and imm8, or Rm
  } dp_instr_t;

endpackage

// File: dp_core_macros.svh
`ifndef DP_CORE_MACROS_SVH
`define DP_CORE_MACROS_SVH

// ******************************
// Core widths
// ******************************
`define DP_XLEN 32         // Data path width
`define DP_NREGS 16        // Register file depth
`define DP_RIDX_W 4        // Register index width

// ******************************
// Operand 2 immediate
// ******************************
// The 4-bit rotate field counts in steps of two bit positions
`define DP_ROT_SCALE 2     // Rotate amount per field step

`endif
